//--- verilog/pcs_rx_pkg.sv
package pcs_rx_pkg;

  ////////////////////////////////////////
  // Lane count and datapath widths
  ////////////////////////////////////////
  localparam int NUM_LANES  = 4;
  localparam int RAW_WIDTH  = 32;
  localparam int DATA_WIDTH = 32;
  localparam int HDR_WIDTH  = 2;

  // Gearbox bit buffer and its fill count
  localparam int BUF_WIDTH  = 100;
  localparam int FILL_WIDTH = 7;

  // Scrambler polynomial 1 + x^39 + x^58
  localparam int SCR_WIDTH = 58;
  localparam int SCR_TAP   = 39;

  ////////////////////////////////////////
  // Block lock thresholds
  ////////////////////////////////////////
  localparam int LOCK_GOOD_COUNT  = 64;
  localparam int UNLOCK_WINDOW    = 64;
  localparam int UNLOCK_BAD_COUNT = 16;
  localparam int SLIP_WAIT        = 4;

  localparam int GOOD_CNT_WIDTH = $clog2(LOCK_GOOD_COUNT);
  localparam int WIN_CNT_WIDTH  = $clog2(UNLOCK_WINDOW);
  localparam int BAD_CNT_WIDTH  = $clog2(UNLOCK_BAD_COUNT);
  localparam int WAIT_CNT_WIDTH = $clog2(SLIP_WAIT);

  // Saturating status counters
  localparam int CNT_WIDTH = 8;

  typedef enum logic [1:0] {HUNT, SLIP_WAIT_ST, TEST, LOCKED} lock_state_t;

endpackage

//--- verilog/rx_lane_if.sv
`timescale 1ns/1ps

interface rx_lane_if;
  import pcs_rx_pkg::*;

  // Half-block stream from the gearbox
  logic [DATA_WIDTH-1:0] data;
  logic                  data_valid;
  logic [HDR_WIDTH-1:0]  header;
  logic                  header_valid;
  // Bit slip request back to the gearbox
  logic                  slip;

  modport gearbox_side (output data, data_valid, header, header_valid, input slip);

  modport sync_side (input header, header_valid, output slip);

endinterface

//--- verilog/rx_gearbox.sv
`timescale 1ns/1ps

module rx_gearbox (
  input  logic                             clkout,
  input  logic                             reset,
  input  logic [pcs_rx_pkg::RAW_WIDTH-1:0] raw_data,
  input  logic                             raw_valid,
  rx_lane_if.gearbox_side                  lane
);
  import pcs_rx_pkg::*;

  // Bit buffer, oldest bit at index 0; bits at and above fill stay zero
  logic [BUF_WIDTH-1:0]  bit_buf;
  logic [FILL_WIDTH-1:0] fill;
  // 0 = header plus first half, 1 = second half
  logic                  phase;
  logic                  slip_pend;

  logic                  drop;
  logic                  emit;
  logic [FILL_WIDTH-1:0] avail;
  logic [FILL_WIDTH-1:0] need;
  logic [FILL_WIDTH-1:0] used;
  logic [FILL_WIDTH-1:0] keep;
  logic [BUF_WIDTH-1:0]  head;
  logic [BUF_WIDTH-1:0]  rest;
  logic [BUF_WIDTH-1:0]  raw_ext;

  ////////////////////////////////////////
  // Emit and consume decision
  ////////////////////////////////////////
  always_comb begin
    // Pending slip is applied together with the next raw word
    drop    = slip_pend && raw_valid && (fill != '0);
    avail   = fill - FILL_WIDTH'(drop);
    head    = bit_buf >> drop;
    need    = phase ? FILL_WIDTH'(DATA_WIDTH) : FILL_WIDTH'(HDR_WIDTH + DATA_WIDTH);
    emit    = (avail >= need);
    used    = FILL_WIDTH'(drop) + (emit ? need : '0);
    keep    = fill - used;
    rest    = bit_buf >> used;
    raw_ext = BUF_WIDTH'(raw_data);
  end

  ////////////////////////////////////////
  // Buffer, phase and strobes
  ////////////////////////////////////////
  always_ff @(posedge clkout) begin
    if (reset) begin
      bit_buf           <= '0;
      fill              <= '0;
      phase             <= 1'b0;
      slip_pend         <= 1'b0;
      lane.data_valid   <= 1'b0;
      lane.header_valid <= 1'b0;
    end else begin
      // New word lands right above the remaining bits
      if (raw_valid) begin
        bit_buf <= rest | (raw_ext << keep);
        fill    <= keep + FILL_WIDTH'(RAW_WIDTH);
      end else begin
        bit_buf <= rest;
        fill    <= keep;
      end
      if (emit) begin
        phase <= ~phase;
      end
      if (lane.slip) begin
        slip_pend <= 1'b1;
      end else if (drop) begin
        slip_pend <= 1'b0;
      end
      lane.data_valid   <= emit;
      lane.header_valid <= emit && !phase;
    end
  end

  // Half-block payload
  always_ff @(posedge clkout) begin
    if (emit) begin
      lane.data <= phase ? head[DATA_WIDTH-1:0] : head[HDR_WIDTH +: DATA_WIDTH];
    end
    if (emit && !phase) begin
      lane.header <= head[HDR_WIDTH-1:0];
    end
  end

endmodule

//--- verilog/block_lock.sv
`timescale 1ns/1ps

module block_lock (
  input  logic         clkout,
  input  logic         reset,
  rx_lane_if.sync_side lane,
  output logic         locked
);
  import pcs_rx_pkg::*;

  lock_state_t               state;
  logic [GOOD_CNT_WIDTH-1:0] good_cnt;
  logic [WIN_CNT_WIDTH-1:0]  win_cnt;
  logic [BAD_CNT_WIDTH-1:0]  bad_cnt;
  logic [WAIT_CNT_WIDTH-1:0] wait_cnt;
  logic                      hdr_ok;

  // Only 01 and 10 are legal sync headers
  assign hdr_ok = lane.header[0] ^ lane.header[1];

  assign locked = (state == LOCKED);

  ////////////////////////////////////////
  // Lock FSM, advanced once per header
  ////////////////////////////////////////
  always_ff @(posedge clkout) begin
    if (reset) begin
      state     <= HUNT;
      good_cnt  <= '0;
      win_cnt   <= '0;
      bad_cnt   <= '0;
      wait_cnt  <= '0;
      lane.slip <= 1'b0;
    end else begin
      lane.slip <= 1'b0;
      if (lane.header_valid) begin
        case (state)
          HUNT: begin
            if (hdr_ok) begin
              good_cnt <= GOOD_CNT_WIDTH'(1);
              state    <= TEST;
            end else begin
              lane.slip <= 1'b1;
              wait_cnt  <= '0;
              state     <= SLIP_WAIT_ST;
            end
          end
          // Headers still in flight from before the slip
          SLIP_WAIT_ST: begin
            if (wait_cnt == WAIT_CNT_WIDTH'(SLIP_WAIT - 1)) begin
              state <= HUNT;
            end else begin
              wait_cnt <= wait_cnt + 1'b1;
            end
          end
          TEST: begin
            if (!hdr_ok) begin
              lane.slip <= 1'b1;
              wait_cnt  <= '0;
              state     <= SLIP_WAIT_ST;
            end else if (good_cnt == GOOD_CNT_WIDTH'(LOCK_GOOD_COUNT - 1)) begin
              win_cnt <= '0;
              bad_cnt <= '0;
              state   <= LOCKED;
            end else begin
              good_cnt <= good_cnt + 1'b1;
            end
          end
          LOCKED: begin
            if (!hdr_ok && bad_cnt == BAD_CNT_WIDTH'(UNLOCK_BAD_COUNT - 1)) begin
              state <= HUNT;
            end else if (win_cnt == WIN_CNT_WIDTH'(UNLOCK_WINDOW - 1)) begin
              // Window closed, start a fresh one
              win_cnt <= '0;
              bad_cnt <= '0;
            end else begin
              win_cnt <= win_cnt + 1'b1;
              if (!hdr_ok) begin
                bad_cnt <= bad_cnt + 1'b1;
              end
            end
          end
          default: state <= HUNT;
        endcase
      end
    end
  end

endmodule

//--- verilog/descrambler.sv
`timescale 1ns/1ps

module descrambler (
  input  logic                              clkout,
  input  logic                              reset,
  input  logic [pcs_rx_pkg::DATA_WIDTH-1:0] din,
  input  logic                              din_valid,
  input  logic [pcs_rx_pkg::HDR_WIDTH-1:0]  hdr_in,
  input  logic                              hdr_in_valid,
  output logic [pcs_rx_pkg::DATA_WIDTH-1:0] dout,
  output logic                              dout_valid,
  output logic [pcs_rx_pkg::HDR_WIDTH-1:0]  hdr_out,
  output logic                              hdr_out_valid
);
  import pcs_rx_pkg::*;

  // Last 58 received scrambled bits, newest at index 0
  logic [SCR_WIDTH-1:0]  scr_state;
  logic [SCR_WIDTH-1:0]  next_state;
  logic [DATA_WIDTH-1:0] plain;

  // Serial descrambler unrolled over the half, LSB first
  always_comb begin
    next_state = scr_state;
    for (int i = 0; i < DATA_WIDTH; i++) begin
      plain[i]   = din[i] ^ next_state[SCR_TAP-1] ^ next_state[SCR_WIDTH-1];
      next_state = {next_state[SCR_WIDTH-2:0], din[i]};
    end
  end

  always_ff @(posedge clkout) begin
    if (reset) begin
      dout_valid    <= 1'b0;
      hdr_out_valid <= 1'b0;
    end else begin
      dout_valid    <= din_valid;
      hdr_out_valid <= hdr_in_valid;
    end
  end

  always_ff @(posedge clkout) begin
    if (din_valid) begin
      scr_state <= next_state;
      dout      <= plain;
    end
    // Header bypasses the scrambler
    hdr_out <= hdr_in;
  end

endmodule

//--- verilog/lane_output.sv
`timescale 1ns/1ps

module lane_output (
  input  logic                              clkout,
  input  logic                              reset,
  input  logic [pcs_rx_pkg::DATA_WIDTH-1:0] din,
  input  logic                              din_valid,
  input  logic [pcs_rx_pkg::HDR_WIDTH-1:0]  hdr_in,
  input  logic                              hdr_in_valid,
  input  logic                              locked,
  input  logic                              slip,
  output logic [pcs_rx_pkg::DATA_WIDTH-1:0] dout,
  output logic                              dvld,
  output logic [pcs_rx_pkg::HDR_WIDTH-1:0]  hdr,
  output logic                              hdrvld,
  output logic [pcs_rx_pkg::CNT_WIDTH-1:0]  bad_hdr_count,
  output logic [pcs_rx_pkg::CNT_WIDTH-1:0]  slip_count
);
  import pcs_rx_pkg::*;

  logic bad_hdr;

  // 00 and 11 are invalid sync headers
  assign bad_hdr = hdr_in_valid && (hdr_in[0] == hdr_in[1]);

  always_ff @(posedge clkout) begin
    if (reset) begin
      dvld          <= 1'b0;
      hdrvld        <= 1'b0;
      bad_hdr_count <= '0;
      slip_count    <= '0;
    end else begin
      // Nothing leaves an unlocked lane
      dvld   <= din_valid && locked;
      hdrvld <= hdr_in_valid && locked;
      if (bad_hdr && locked && bad_hdr_count != '1) begin
        bad_hdr_count <= bad_hdr_count + 1'b1;
      end
      if (slip && slip_count != '1) begin
        slip_count <= slip_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clkout) begin
    dout <= din;
    hdr  <= hdr_in;
  end

endmodule

//--- verilog/pcs_rx_top.sv
`timescale 1ns/1ps

module pcs_rx_top (
  input  logic                                                 clkout,
  input  logic                                                 reset,
  input  logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::RAW_WIDTH-1:0]  raw_data,
  input  logic [pcs_rx_pkg::NUM_LANES-1:0]                     raw_valid,
  output logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::DATA_WIDTH-1:0] dout,
  output logic [pcs_rx_pkg::NUM_LANES-1:0]                     dvld,
  output logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::HDR_WIDTH-1:0]  hdr,
  output logic [pcs_rx_pkg::NUM_LANES-1:0]                     hdrvld,
  output logic [pcs_rx_pkg::NUM_LANES-1:0]                     locked,
  output logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::CNT_WIDTH-1:0]  bad_hdr_count,
  output logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::CNT_WIDTH-1:0]  slip_count
);
  import pcs_rx_pkg::*;

  ////////////////////////////////////////
  // One receive chain per lane
  ////////////////////////////////////////
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    rx_lane_if lane_if ();

    logic [DATA_WIDTH-1:0] ds_data;
    logic                  ds_valid;
    logic [HDR_WIDTH-1:0]  ds_hdr;
    logic                  ds_hdr_valid;

    rx_gearbox u_gearbox (
      .clkout    (clkout),
      .reset     (reset),
      .raw_data  (raw_data[i*RAW_WIDTH +: RAW_WIDTH]),
      .raw_valid (raw_valid[i]),
      .lane      (lane_if.gearbox_side)
    );

    block_lock u_block_lock (
      .clkout (clkout),
      .reset  (reset),
      .lane   (lane_if.sync_side),
      .locked (locked[i])
    );

    descrambler u_descrambler (
      .clkout        (clkout),
      .reset         (reset),
      .din           (lane_if.data),
      .din_valid     (lane_if.data_valid),
      .hdr_in        (lane_if.header),
      .hdr_in_valid  (lane_if.header_valid),
      .dout          (ds_data),
      .dout_valid    (ds_valid),
      .hdr_out       (ds_hdr),
      .hdr_out_valid (ds_hdr_valid)
    );

    // Status counters and gated outputs
    lane_output u_lane_output (
      .clkout        (clkout),
      .reset         (reset),
      .din           (ds_data),
      .din_valid     (ds_valid),
      .hdr_in        (ds_hdr),
      .hdr_in_valid  (ds_hdr_valid),
      .locked        (locked[i]),
      .slip          (lane_if.slip),
      .dout          (dout[i*DATA_WIDTH +: DATA_WIDTH]),
      .dvld          (dvld[i]),
      .hdr           (hdr[i*HDR_WIDTH +: HDR_WIDTH]),
      .hdrvld        (hdrvld[i]),
      .bad_hdr_count (bad_hdr_count[i*CNT_WIDTH +: CNT_WIDTH]),
      .slip_count    (slip_count[i*CNT_WIDTH +: CNT_WIDTH])
    );
  end

endmodule

//--- sim/pcs_rx_sva.sv
`timescale 1ns/1ps

module pcs_rx_sva (
  input logic                             clkout,
  input logic                             reset,
  input logic                             slip,
  input logic [pcs_rx_pkg::HDR_WIDTH-1:0] header,
  input logic                             header_valid,
  input logic                             locked
);
  import pcs_rx_pkg::*;

  logic       bad_hdr;
  logic [7:0] good_run;
  logic [7:0] since_slip;

  // 00 and 11 are not sync headers
  assign bad_hdr = (header == 2'b00) || (header == 2'b11);

  // Run of legal headers, and headers seen since the last slip
  always_ff @(posedge clkout) begin
    if (reset) begin
      good_run   <= '0;
      since_slip <= '1;
    end else begin
      if (header_valid) begin
        if (bad_hdr) begin
          good_run <= '0;
        end else if (good_run != '1) begin
          good_run <= good_run + 1'b1;
        end
      end
      if (slip) begin
        since_slip <= '0;
      end else if (header_valid && since_slip != '1) begin
        since_slip <= since_slip + 1'b1;
      end
    end
  end

  // Slip answers a bad header just judged
  a_slip_cause: assert property (@(posedge clkout) disable iff (reset)
    slip |-> $past(header_valid && bad_hdr))
    else $error("slip without a preceding bad header");

  // Headers right after a slip are ignored
  a_slip_hold_off: assert property (@(posedge clkout) disable iff (reset)
    slip |-> since_slip > SLIP_WAIT)
    else $error("slip issued inside the hold-off after a previous slip");

  a_bad_hdr_slip: assert property (@(posedge clkout) disable iff (reset)
    header_valid && bad_hdr && !locked && since_slip >= SLIP_WAIT |=> slip)
    else $error("bad header while hunting was not answered by a slip");

  a_lock_run: assert property (@(posedge clkout) disable iff (reset)
    $rose(locked) |-> good_run >= LOCK_GOOD_COUNT)
    else $error("lock declared before enough consecutive legal headers");

endmodule

bind block_lock pcs_rx_sva u_sva (
  .clkout       (clkout),
  .reset        (reset),
  .slip         (lane.slip),
  .header       (lane.header),
  .header_valid (lane.header_valid),
  .locked       (locked)
);

//--- sim/pcs_rx_checker.sv
`timescale 1ns/1ps

module pcs_rx_checker (
  input  logic                                                    clkout,
  input  logic                                                    reset,
  input  logic [2:0]                                              stage,
  input  int unsigned                                             nblk,
  input  logic [63:0]                                             blk_pay [16],
  input  logic [1:0]                                              blk_hdr [16],
  input  int unsigned                                             lane_off [pcs_rx_pkg::NUM_LANES],
  input  int unsigned                                             iso_count,
  input  logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::DATA_WIDTH-1:0] dout,
  input  logic [pcs_rx_pkg::NUM_LANES-1:0]                        dvld,
  input  logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::HDR_WIDTH-1:0]  hdr,
  input  logic [pcs_rx_pkg::NUM_LANES-1:0]                        hdrvld,
  input  logic [pcs_rx_pkg::NUM_LANES-1:0]                        locked,
  input  logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::CNT_WIDTH-1:0]  bad_hdr_count,
  input  logic [pcs_rx_pkg::NUM_LANES*pcs_rx_pkg::CNT_WIDTH-1:0]  slip_count,
  output int                                                      err_count,
  output int                                                      test_count,
  output logic                                                    done
);
  import pcs_rx_pkg::*;

  logic [2:0]            stage_q;
  logic                  rst_q;
  logic [NUM_LANES-1:0]  locked_q, have_low, skip_blk, fell, relocked, iso_drop;
  logic [DATA_WIDTH-1:0] low_half [NUM_LANES];
  logic [HDR_WIDTH-1:0]  low_hdr [NUM_LANES];
  logic [CNT_WIDTH-1:0]  bad_base [NUM_LANES];
  int unsigned           blk_seen [NUM_LANES];
  int unsigned           blk_after [NUM_LANES];
  int                    reset_err;
  int                    data_err;

  initial begin
    stage_q    = '0;
    rst_q      = 1'b0;
    locked_q   = '0;
    have_low   = '0;
    skip_blk   = '0;
    fell       = '0;
    relocked   = '0;
    iso_drop   = '0;
    reset_err  = 0;
    data_err   = 0;
    err_count  = 0;
    test_count = 0;
    done       = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      blk_seen[l]  = 0;
      blk_after[l] = 0;
      bad_base[l]  = '0;
    end
  end

  function automatic logic [CNT_WIDTH-1:0] lane_cnt(logic [NUM_LANES*CNT_WIDTH-1:0] v, int l);
    return v[l*CNT_WIDTH +: CNT_WIDTH];
  endfunction

  task automatic finish_test(string name, int errs);
    test_count++;
    err_count += errs;
    if (errs == 0) begin
      $display("[%0t] %s check ok", $time, name);
    end else begin
      $display("[%0t] %s check: %0d errors", $time, name, errs);
    end
  endtask

  task automatic compare_block(int l, logic [31:0] lo, logic [31:0] hi, logic [1:0] h);
    int unsigned idx;
    logic [1:0]  exp_h;
    idx = lo[15:0];
    if (idx >= nblk) begin
      data_err++;
      $display("Error: %0t: lane %0d index %0d is not in the block list", $time, l, idx);
    end else begin
      exp_h = blk_hdr[idx];
      // Corrupted headers, repeating their first bit, exist only in pass two before relock
      if (stage_q >= 3'd2 && !relocked[l] && h[0] == h[1]) begin
        exp_h = {exp_h[0], exp_h[0]};
      end
      if ({hi, lo} !== blk_pay[idx] || h !== exp_h) begin
        data_err++;
        $display("Error: %0t: lane %0d block %0d got %b/%h, expected %b/%h",
                 $time, l, idx, h, {hi, lo}, exp_h, blk_pay[idx]);
      end
    end
  endtask

  ////////////////////////////////////////
  // End-of-section checks
  ////////////////////////////////////////
  task automatic check_lock();
    int errs;
    errs = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (!locked[l]) begin
        errs++;
        $display("Lane %0d did not reach lock in the first pass", l);
      end
      if ((lane_cnt(slip_count, l) != 0) != (lane_off[l] != 0)) begin
        errs++;
        $display("Error: %0t: lane %0d slip count %0d with bit offset %0d",
                 $time, l, lane_cnt(slip_count, l), lane_off[l]);
      end
      bad_base[l] = lane_cnt(bad_hdr_count, l);
    end
    finish_test("lock", errs);
  endtask

  task automatic check_bad_count();
    int errs;
    errs = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (CNT_WIDTH'(lane_cnt(bad_hdr_count, l) - bad_base[l]) != CNT_WIDTH'(iso_count)) begin
        errs++;
        $display("Error: %0t: lane %0d bad header count rose by %0d, expected %0d", $time, l,
                 CNT_WIDTH'(lane_cnt(bad_hdr_count, l) - bad_base[l]), iso_count);
      end
      if (iso_drop[l]) begin
        errs++;
        $display("Lane %0d lost lock on isolated bad headers", l);
      end
    end
    finish_test("bad header", errs);
  endtask

  task automatic check_end();
    int errs;
    errs = 0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (blk_seen[l] == 0) begin
        data_err++;
        $display("Lane %0d delivered no complete block", l);
      end
      if (!fell[l] || !relocked[l] || blk_after[l] == 0) begin
        errs++;
        $display("Lane %0d did not drop, relock and deliver data after the burst", l);
      end
    end
    finish_test("data", data_err);
    finish_test("relock", errs);
  endtask

  always @(posedge clkout) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      // Cleared outputs while reset holds and one cycle after
      if (rst_q && (dvld[l] || hdrvld[l] || locked[l] || lane_cnt(bad_hdr_count, l) != 0 ||
                    lane_cnt(slip_count, l) != 0)) begin
        reset_err++;
        $display("Error: %0t: lane %0d outputs not cleared by reset", $time, l);
      end
      if (locked[l] && !locked_q[l]) begin
        skip_blk[l] = 1'b1;
        if (fell[l]) begin
          relocked[l] = 1'b1;
        end
      end
      if (!locked[l] && locked_q[l] && stage_q == 3'd3) begin
        fell[l] = 1'b1;
      end
      if (!locked[l] && stage_q == 3'd2) begin
        iso_drop[l] = 1'b1;
      end
      if (!locked[l]) begin
        have_low[l] = 1'b0;
      end
      if (hdrvld[l]) begin
        low_half[l] = dout[l*DATA_WIDTH +: DATA_WIDTH];
        low_hdr[l]  = hdr[l*HDR_WIDTH +: HDR_WIDTH];
        have_low[l] = 1'b1;
      end else if (dvld[l] && have_low[l]) begin
        have_low[l] = 1'b0;
        // Descrambler may still be settling on the first block
        if (skip_blk[l]) begin
          skip_blk[l] = 1'b0;
        end else begin
          compare_block(l, low_half[l], dout[l*DATA_WIDTH +: DATA_WIDTH], low_hdr[l]);
          blk_seen[l]++;
          if (relocked[l]) begin
            blk_after[l]++;
          end
        end
      end
      locked_q[l] = locked[l];
    end
    if (stage != stage_q) begin
      case (stage)
        3'd2: begin
          finish_test("reset", reset_err);
          check_lock();
        end
        3'd3: check_bad_count();
        3'd4: begin
          check_end();
          done = 1'b1;
        end
        default: ;
      endcase
    end
    stage_q = stage;
    rst_q   = reset;
  end

endmodule

//--- sim/tb_pcs_rx.sv
`timescale 1ns/1ps

module tb_pcs_rx;
  import pcs_rx_pkg::*;

  logic                            clkout;
  logic                            reset;
  logic [NUM_LANES*RAW_WIDTH-1:0]  raw_data;
  logic [NUM_LANES-1:0]            raw_valid;
  logic [NUM_LANES*DATA_WIDTH-1:0] dout;
  logic [NUM_LANES-1:0]            dvld;
  logic [NUM_LANES*HDR_WIDTH-1:0]  hdr;
  logic [NUM_LANES-1:0]            hdrvld;
  logic [NUM_LANES-1:0]            locked;
  logic [NUM_LANES*CNT_WIDTH-1:0]  bad_hdr_count;
  logic [NUM_LANES*CNT_WIDTH-1:0]  slip_count;

  // File image, settings at 0x00 and blocks from 0x20
  logic [67:0] tdata [0:63];
  logic [63:0] blk_pay [16];
  logic [1:0]  blk_hdr [16];
  int unsigned lane_off [NUM_LANES];
  int unsigned nblk, pass1_len, pass2_len, burst_pos, burst_len, iso_count;
  bit          stream [$];
  logic [2:0]  stage;
  logic        loaded;
  logic        chk_done;
  int          err_count;
  int          test_count;

  pcs_rx_top u_dut (
    .clkout (clkout), .reset (reset), .raw_data (raw_data), .raw_valid (raw_valid),
    .dout (dout), .dvld (dvld), .hdr (hdr), .hdrvld (hdrvld), .locked (locked),
    .bad_hdr_count (bad_hdr_count), .slip_count (slip_count)
  );

  pcs_rx_checker u_checker (
    .clkout (clkout), .reset (reset), .stage (stage), .nblk (nblk), .blk_pay (blk_pay),
    .blk_hdr (blk_hdr), .lane_off (lane_off), .iso_count (iso_count), .dout (dout),
    .dvld (dvld), .hdr (hdr), .hdrvld (hdrvld), .locked (locked),
    .bad_hdr_count (bad_hdr_count), .slip_count (slip_count),
    .err_count (err_count), .test_count (test_count), .done (chk_done)
  );

  initial begin
    clkout = 1'b0;
    forever #10 clkout = ~clkout;
  end

  // Position counted from the start of the second pass
  function automatic bit is_corrupt(int unsigned pos);
    if (pos >= burst_pos && pos < burst_pos + burst_len) begin
      return 1'b1;
    end
    for (int unsigned k = 0; k < iso_count; k++) begin
      if (tdata[10+k][31:0] == pos) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic load_testdata();
    logic [63:0] pay;
    $readmemh("sim/pcs_rx_testdata.txt", tdata);
    nblk      = tdata[0][31:0];
    pass1_len = tdata[5][31:0];
    pass2_len = tdata[6][31:0];
    burst_pos = tdata[7][31:0];
    burst_len = tdata[8][31:0];
    iso_count = tdata[9][31:0];
    for (int l = 0; l < NUM_LANES; l++) begin
      lane_off[l] = tdata[1+l][31:0];
    end
    for (int i = 0; i < 16; i++) begin
      pay = tdata[32+i][63:0];
      // Zero bytes above the index get random values
      for (int b = 2; b < 8; b++) begin
        if (pay[8*b +: 8] == 8'h00) begin
          pay[8*b +: 8] = 8'($urandom());
        end
      end
      blk_pay[i] = pay;
      blk_hdr[i] = tdata[32+i][65:64];
    end
  endtask

  task automatic build_stream();
    logic [SCR_WIDTH-1:0] scr;
    logic [1:0]           h;
    logic [63:0]          p;
    bit                   s;
    int unsigned          idx;
    scr = '0;
    for (int unsigned b = 0; b < pass1_len + pass2_len; b++) begin
      idx = b % nblk;
      h   = blk_hdr[idx];
      p   = blk_pay[idx];
      if (b >= pass1_len && is_corrupt(b - pass1_len)) begin
        h = {h[0], h[0]};
      end
      stream.push_back(h[0]);
      stream.push_back(h[1]);
      // Payload LSB first through 1 + x^39 + x^58
      for (int i = 0; i < 64; i++) begin
        s   = p[i] ^ scr[SCR_TAP-1] ^ scr[SCR_WIDTH-1];
        scr = {scr[SCR_WIDTH-2:0], s};
        stream.push_back(s);
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  initial begin
    logic [NUM_LANES*RAW_WIDTH-1:0] word;
    int unsigned                    nwords;
    int unsigned                    w;
    int unsigned                    cyc;
    int unsigned                    blk;
    reset     = 1'b1;
    raw_data  = '0;
    raw_valid = '0;
    stage     = 3'd0;
    loaded    = 1'b0;
    void'($urandom(97516));
    load_testdata();
    build_stream();
    loaded = 1'b1;
    repeat (16) @(posedge clkout);
    reset <= 1'b0;
    stage <= 3'd1;
    nwords = (stream.size() - 66) / RAW_WIDTH;
    w      = 0;
    cyc    = 0;
    while (w < nwords) begin
      @(posedge clkout);
      cyc++;
      // Idle slot now and then to stall the gearbox
      if (cyc % 13 == 0) begin
        raw_valid <= '0;
      end else begin
        for (int l = 0; l < NUM_LANES; l++) begin
          for (int j = 0; j < RAW_WIDTH; j++) begin
            word[l*RAW_WIDTH+j] = stream[lane_off[l] + w*RAW_WIDTH + j];
          end
        end
        blk = (w * RAW_WIDTH) / 66;
        raw_data  <= word;
        raw_valid <= '1;
        stage <= (blk < pass1_len) ? 3'd1 : (blk < pass1_len + burst_pos) ? 3'd2 : 3'd3;
        w++;
      end
    end
    @(posedge clkout);
    raw_valid <= '0;
    repeat (20) @(posedge clkout);
    stage <= 3'd4;
    wait (chk_done);
    @(posedge clkout);
    $display("Summary: %0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (loaded);
    repeat (pass2_len * 2 * 40 * 2) @(posedge clkout);
    $display("Watchdog expired before all checks completed");
    $display("Test failed");
    $finish;
  end

endmodule

//--- sim/pcs_rx_testdata.txt
// 0x00 block count, 0x01-0x04 lane bit offsets, 0x05/0x06 pass lengths in blocks
// 0x07/0x08 burst start and length, 0x09 isolated count, 0x0A.. isolated positions
@0
10
0
32
3C
41
190
578
FA
20
3
3C
82
C8
// Blocks: header digit, then 64-bit payload with the index in bits 15:0
@20
10000000000000000
2DEADBEEF00000001
10000000000000002
1A5A5A5A5A5A50003
20000000000000004
10000000000000005
20123456789AB0006
10000000000000007
2FFFFFFFFFFFF0008
10000000000000009
2000000000000000A
1C3C3C3C3C3C3000B
2000000000000000C
1000000000000000D
20F0F0F0F0F0F000E
1000000000000000F

//--- sim.f
verilog/pcs_rx_pkg.sv
verilog/rx_lane_if.sv
verilog/rx_gearbox.sv
verilog/block_lock.sv
verilog/descrambler.sv
verilog/lane_output.sv
verilog/pcs_rx_top.sv
sim/pcs_rx_sva.sv
sim/pcs_rx_checker.sv
sim/tb_pcs_rx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_pcs_rx \
  -o sim_pcs_rx && ./obj_dir/sim_pcs_rx > sim.log 2>&1 || { cat sim.log 2>/dev/null; exit 1; }
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log || exit 1
exit 0
